/* sim.f */
lc4_pkg.sv
lc4_fetch.sv
lc4_regfile.sv
lc4_decode.sv
lc4_execute.sv
lc4_memory.sv
lc4_writeback.sv
lc4_core.sv
tb_lc4_core.sv

/* run_sim.sh */
#!/bin/sh
# build the LC4 core testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_lc4_core -f sim.f -o tb_lc4_core \
    && { ./obj_dir/tb_lc4_core > sim.log 2>&1; cat sim.log; } \
    && ! grep -q "STATUS: FAIL" sim.log \
    && grep -q "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb_lc4_core.sv */
module tb_lc4_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int             clk_period   = 4;
    localparam int             reset_cycles = 16;
    localparam int             n_entries    = 27;
    localparam lc4_pkg::word_t reset_pc     = 16'h8200;
    localparam lc4_pkg::word_t halt_pc      = reset_pc + 16'(n_entries - 1);

    localparam lc4_pkg::nzp_t nzp_n    = 3'b100;
    localparam lc4_pkg::nzp_t nzp_z    = 3'b010;
    localparam lc4_pkg::nzp_t nzp_p    = 3'b001;
    localparam lc4_pkg::nzp_t nzp_none = 3'b000;

    // one program word and the retire entry it should produce
    // gap counts cycles since the previous retirement, or since the fetch cycle for the first
    typedef struct packed {
        lc4_pkg::insn_t    insn;
        logic              retires;
        logic              rd_we;
        lc4_pkg::reg_sel_t rd;
        lc4_pkg::word_t    data;
        logic              nzp_we;
        lc4_pkg::nzp_t     nzp;
        logic [2:0]        gap;
    } entry_t;

    logic                  gwe;
    logic                  reset;
    lc4_pkg::word_t        imem_addr;
    lc4_pkg::insn_t        imem_data;
    lc4_pkg::dmem_req_t    dmem_req;
    lc4_pkg::word_t        dmem_rdata;
    lc4_pkg::wb_trace_t    wb;
    lc4_pkg::word_t        imem_off;

    entry_t                tbl [n_entries];
    lc4_pkg::insn_t        imem [32];
    lc4_pkg::word_t        dmem [65536];
    int                    fill_idx = 0;
    int                    seen_retires = 0;

    lc4_core #(.reset_pc(reset_pc)) lc4_core_i (
        .gwe          (gwe),
        .i_reset      (reset),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .o_dmem       (dmem_req),
        .i_dmem_rdata (dmem_rdata),
        .o_wb         (wb)
    );

    initial begin
        gwe = 1'b0;
        forever #(clk_period / 2) gwe = ~gwe;
    end

    // both memories answer in the same cycle
    assign imem_off = imem_addr - reset_pc;
    always_comb begin
        imem_data = (imem_off < 16'd32) ? imem[imem_off[4:0]] : 16'h0000;
    end
    assign dmem_rdata = dmem[dmem_req.addr];

    always @(posedge gwe) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr] <= dmem_req.wdata;
        end
    end

    // every retirement on the trace port, apart from the table walk
    always @(posedge gwe) begin
        if (wb.valid) begin
            seen_retires++;
        end
    end

    // background pattern from the whole address
    initial begin
        for (int a = 0; a < 65536; a++) begin
            dmem[a] = 16'(a) ^ 16'h3c5a;
        end
    end

    initial begin
        #(clk_period * (reset_cycles + 8 * n_entries));
        $display("watchdog expired before the program finished retiring");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic add_entry(input lc4_pkg::insn_t insn, input logic ret, input logic rd_we,
                             input lc4_pkg::reg_sel_t rd, input lc4_pkg::word_t data,
                             input logic nzp_we, input lc4_pkg::nzp_t nzp,
                             input logic [2:0] gap);
        tbl[fill_idx] = '{insn, ret, rd_we, rd, data, nzp_we, nzp, gap};
        fill_idx++;
    endtask

    // rd and data only matter when written, nzp likewise
    task automatic compare_entry(input int idx);
        entry_t e;
        e = tbl[idx];
        check("o_wb.pc", wb.pc, reset_pc + 16'(idx));
        check("o_wb.insn", wb.insn, e.insn);
        check("o_wb.rd_we", 16'(wb.rd_we), 16'(e.rd_we));
        check("o_wb.nzp_we", 16'(wb.nzp_we), 16'(e.nzp_we));
        if (e.rd_we) begin
            check("o_wb.rd", 16'(wb.rd), 16'(e.rd));
            check("o_wb.data", wb.data, e.data);
        end
        if (e.nzp_we) begin
            check("o_wb.nzp", 16'(wb.nzp), 16'(e.nzp));
        end
    endtask

    initial begin
        int cycle;
        int last_retire;
        int expected_retires;
        reset = 1'b1;
        cycle = 0;
        last_retire = 0;
        expected_retires = 0;

        // ALU chain, forwarding from memory and writeback
        add_entry(16'h9205, 1, 1, 3'd1, 16'h0005, 1, nzp_p, 4);    // CONST R1, #5
        add_entry(16'h95FD, 1, 1, 3'd2, 16'hFFFD, 1, nzp_n, 1);    // CONST R2, #-3
        add_entry(16'h1642, 1, 1, 3'd3, 16'h0002, 1, nzp_p, 1);    // ADD R3, R1, R2
        add_entry(16'h18FE, 1, 1, 3'd4, 16'h0000, 1, nzp_z, 1);    // ADD R4, R3, #-2
        add_entry(16'h1A53, 1, 1, 3'd5, 16'h0003, 1, nzp_p, 1);    // SUB R5, R1, R3
        add_entry(16'h5D42, 1, 1, 3'd6, 16'h0001, 1, nzp_p, 1);    // AND R6, R5, R2
        add_entry(16'h5F92, 1, 1, 3'd7, 16'hFFFD, 1, nzp_n, 1);    // OR R7, R6, R2
        add_entry(16'h5FDA, 1, 1, 3'd7, 16'h0000, 1, nzp_z, 1);    // XOR R7, R7, R2
        // store, load back, then a dependent add one bubble later
        add_entry(16'h9040, 1, 1, 3'd0, 16'h0040, 1, nzp_p, 1);    // CONST R0, #64
        add_entry(16'h7403, 1, 0, 3'd0, 16'h0000, 0, nzp_none, 1); // STR R2, R0, #3
        add_entry(16'h6803, 1, 1, 3'd4, 16'hFFFD, 1, nzp_n, 1);    // LDR R4, R0, #3
        add_entry(16'h1B21, 1, 1, 3'd5, 16'hFFFE, 1, nzp_n, 2);    // ADD R5, R4, #1
        // branches on an ALU result and on a load result
        add_entry(16'h9200, 1, 1, 3'd1, 16'h0000, 1, nzp_z, 1);    // CONST R1, #0
        add_entry(16'h0402, 1, 0, 3'd0, 16'h0000, 0, nzp_none, 1); // BRz +2, taken
        add_entry(16'h9C07, 0, 0, 3'd0, 16'h0000, 0, nzp_none, 0); // skipped
        add_entry(16'h9C09, 0, 0, 3'd0, 16'h0000, 0, nzp_none, 0); // skipped
        add_entry(16'h0A01, 1, 0, 3'd0, 16'h0000, 0, nzp_none, 3); // BRnp +1, not taken
        add_entry(16'h6603, 1, 1, 3'd3, 16'hFFFD, 1, nzp_n, 1);    // LDR R3, R0, #3
        add_entry(16'h0802, 1, 0, 3'd0, 16'h0000, 0, nzp_none, 1); // BRn +2, taken
        add_entry(16'h9E01, 0, 0, 3'd0, 16'h0000, 0, nzp_none, 0); // skipped
        add_entry(16'h1FE1, 0, 0, 3'd0, 16'h0000, 0, nzp_none, 0); // skipped
        add_entry(16'h0201, 1, 0, 3'd0, 16'h0000, 0, nzp_none, 3); // BRp +1, not taken
        // no-ops, then proof that R1 was left alone
        add_entry(16'hD3FF, 1, 0, 3'd0, 16'h0000, 0, nzp_none, 1); // HICONST
        add_entry(16'hF0FF, 1, 0, 3'd0, 16'h0000, 0, nzp_none, 1); // TRAP
        add_entry(16'h0005, 1, 0, 3'd0, 16'h0000, 0, nzp_none, 1); // BR with empty mask
        add_entry(16'h1443, 1, 1, 3'd2, 16'hFFFD, 1, nzp_n, 1);    // ADD R2, R1, R3
        add_entry(16'h0FFF, 1, 0, 3'd0, 16'h0000, 0, nzp_none, 1); // BRnzp -1, halt loop

        for (int k = 0; k < 32; k++) begin
            imem[k] = 16'h0000;
            if (k < n_entries) begin
                imem[k] = tbl[k].insn;
                if (tbl[k].retires) begin
                    expected_retires++;
                end
            end
        end

        repeat (reset_cycles) @(posedge gwe);
        reset <= 1'b0;
        // cycle 0 is the fetch cycle of the first instruction
        @(negedge gwe);
        check("o_imem_addr", imem_addr, reset_pc);
        while (!wb.valid) begin
            check("o_dmem.we", 16'(dmem_req.we), 16'd0);
            @(negedge gwe);
            cycle++;
        end

        for (int i = 0; i < n_entries; i++) begin
            if (tbl[i].retires) begin
                while (!wb.valid) begin
                    @(negedge gwe);
                    cycle++;
                end
                compare_entry(i);
                check("retire gap", 16'(cycle - last_retire), 16'(tbl[i].gap));
                last_retire = cycle;
                @(negedge gwe);
                cycle++;
            end
        end
        // the halt branch comes back to writeback only three cycles later
        check("retire count", 16'(seen_retires), 16'(expected_retires));
        // STR R2, R0, #3 left -3 at 64 + 3
        check("dmem[0043]", dmem[16'h0043], 16'hFFFD);

        // only the halt loop may keep retiring
        repeat (8) begin
            @(negedge gwe);
            if (wb.valid) begin
                check("o_wb.pc after halt", wb.pc, halt_pc);
            end
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* lc4_core.sv */
module lc4_core #(
    parameter lc4_pkg::word_t reset_pc = 16'h8200
) (
    input  logic               gwe,
    input  logic               i_reset,
    output lc4_pkg::word_t     o_imem_addr,
    input  lc4_pkg::insn_t     i_imem_data,
    output lc4_pkg::dmem_req_t o_dmem,
    input  lc4_pkg::word_t     i_dmem_rdata,
    output lc4_pkg::wb_trace_t o_wb
);

    lc4_pkg::fd_t       fd;
    lc4_pkg::dx_t       dx;
    lc4_pkg::xm_t       xm;
    lc4_pkg::mw_t       mw;
    lc4_pkg::redirect_t redirect;
    lc4_pkg::fwd_t      m_fwd;
    lc4_pkg::fwd_t      w_fwd;
    lc4_pkg::rf_write_t rf_wr;
    logic               stall;

    lc4_fetch #(.reset_pc(reset_pc)) fetch_i (
        .gwe         (gwe),
        .i_reset     (i_reset),
        .i_stall     (stall),
        .i_redirect  (redirect),
        .o_imem_addr (o_imem_addr),
        .i_imem_data (i_imem_data),
        .o_fd        (fd)
    );

    lc4_decode decode_i (
        .gwe        (gwe),
        .i_reset    (i_reset),
        .i_fd       (fd),
        .i_redirect (redirect),
        .i_wr       (rf_wr),
        .o_stall    (stall),
        .o_dx       (dx)
    );

    lc4_execute execute_i (
        .gwe        (gwe),
        .i_reset    (i_reset),
        .i_dx       (dx),
        .i_m_fwd    (m_fwd),
        .i_w_fwd    (w_fwd),
        .o_redirect (redirect),
        .o_xm       (xm)
    );

    lc4_memory memory_i (
        .gwe          (gwe),
        .i_reset      (i_reset),
        .i_xm         (xm),
        .o_dmem       (o_dmem),
        .i_dmem_rdata (i_dmem_rdata),
        .o_m_fwd      (m_fwd),
        .o_mw         (mw)
    );

    lc4_writeback writeback_i (
        .gwe     (gwe),
        .i_reset (i_reset),
        .i_mw    (mw),
        .o_w_fwd (w_fwd),
        .o_wr    (rf_wr),
        .o_wb    (o_wb)
    );

endmodule

/* lc4_writeback.sv */
module lc4_writeback (
    input  logic               gwe,
    input  logic               i_reset,
    input  lc4_pkg::mw_t       i_mw,
    output lc4_pkg::fwd_t      o_w_fwd,
    output lc4_pkg::rf_write_t o_wr,
    output lc4_pkg::wb_trace_t o_wb
);

    lc4_pkg::nzp_t nzp_reg;
    logic          rd_we;
    logic          nzp_we;

    assign rd_we  = i_mw.valid && i_mw.ctrl.rd_we;
    assign nzp_we = i_mw.valid && i_mw.ctrl.nzp_we;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            nzp_reg <= '0;
        end else if (nzp_we) begin
            nzp_reg <= i_mw.nzp;
        end
    end

    assign o_wr = '{we: rd_we, rd: i_mw.ctrl.rd, data: i_mw.result};

    // nzp here is what the register will hold after this cycle
    assign o_w_fwd = '{valid: i_mw.valid, we: i_mw.ctrl.rd_we, rd: i_mw.ctrl.rd,
                       data: i_mw.result, nzp_we: i_mw.ctrl.nzp_we,
                       nzp: nzp_we ? i_mw.nzp : nzp_reg};

    assign o_wb = '{valid: i_mw.valid, pc: i_mw.pc, insn: i_mw.insn, rd_we: rd_we,
                    rd: i_mw.ctrl.rd, data: i_mw.result, nzp_we: nzp_we, nzp: i_mw.nzp};

endmodule

/* lc4_memory.sv */
module lc4_memory (
    input  logic               gwe,
    input  logic               i_reset,
    input  lc4_pkg::xm_t       i_xm,
    output lc4_pkg::dmem_req_t o_dmem,
    input  lc4_pkg::word_t     i_dmem_rdata,
    output lc4_pkg::fwd_t      o_m_fwd,
    output lc4_pkg::mw_t       o_mw
);

    logic           is_load;
    logic           is_store;
    lc4_pkg::word_t final_data;
    lc4_pkg::nzp_t  final_nzp;

    assign is_load  = i_xm.valid && i_xm.ctrl.is_load;
    assign is_store = i_xm.valid && i_xm.ctrl.is_store;

    assign o_dmem.we    = is_store;
    assign o_dmem.addr  = (is_load || is_store) ? i_xm.result : '0;
    assign o_dmem.wdata = is_store ? i_xm.store_data : '0;

    // read data arrives in the same cycle
    assign final_data = is_load ? i_dmem_rdata : i_xm.result;
    assign final_nzp  = is_load ? lc4_pkg::nzp_of(i_dmem_rdata) : i_xm.nzp;

    assign o_m_fwd = '{valid: i_xm.valid, we: i_xm.ctrl.rd_we, rd: i_xm.ctrl.rd,
                       data: final_data, nzp_we: i_xm.ctrl.nzp_we, nzp: final_nzp};

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_mw.valid <= 1'b0;
        end else begin
            o_mw <= '{valid: i_xm.valid, pc: i_xm.pc, insn: i_xm.insn, ctrl: i_xm.ctrl,
                      result: final_data, nzp: final_nzp};
        end
    end

endmodule

/* lc4_execute.sv */
module lc4_execute (
    input  logic               gwe,
    input  logic               i_reset,
    input  lc4_pkg::dx_t       i_dx,
    input  lc4_pkg::fwd_t      i_m_fwd,
    input  lc4_pkg::fwd_t      i_w_fwd,
    output lc4_pkg::redirect_t o_redirect,
    output lc4_pkg::xm_t       o_xm
);

    lc4_pkg::word_t rs_val;
    lc4_pkg::word_t rt_val;
    lc4_pkg::word_t op_b;
    lc4_pkg::word_t result;
    lc4_pkg::nzp_t  br_nzp;

    // memory stage is younger than writeback, so it is checked first
    function automatic lc4_pkg::word_t forward(lc4_pkg::reg_sel_t r,
                                               lc4_pkg::word_t rf_val,
                                               lc4_pkg::fwd_t m,
                                               lc4_pkg::fwd_t w);
        if (m.valid && m.we && m.rd == r) begin
            return m.data;
        end
        if (w.valid && w.we && w.rd == r) begin
            return w.data;
        end
        return rf_val;
    endfunction

    assign rs_val = forward(i_dx.ctrl.rs, i_dx.rs_data, i_m_fwd, i_w_fwd);
    assign rt_val = forward(i_dx.ctrl.rt, i_dx.rt_data, i_m_fwd, i_w_fwd);
    assign op_b   = i_dx.ctrl.use_imm ? i_dx.ctrl.imm : rt_val;

    always_comb begin
        case (i_dx.ctrl.alu_op)
            lc4_pkg::alu_add:  result = rs_val + op_b;
            lc4_pkg::alu_sub:  result = rs_val - op_b;
            lc4_pkg::alu_and:  result = rs_val & op_b;
            lc4_pkg::alu_or:   result = rs_val | op_b;
            lc4_pkg::alu_xor:  result = rs_val ^ op_b;
            lc4_pkg::alu_pass: result = i_dx.ctrl.imm;
            default:           result = '0;
        endcase
    end

    // writeback already folds in the NZP register value
    assign br_nzp = (i_m_fwd.valid && i_m_fwd.nzp_we) ? i_m_fwd.nzp : i_w_fwd.nzp;

    assign o_redirect.taken  = i_dx.valid && i_dx.ctrl.is_branch &&
                               ((i_dx.ctrl.br_mask & br_nzp) != 3'b000);
    assign o_redirect.target = i_dx.pc + 16'd1 + i_dx.ctrl.imm;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_xm.valid <= 1'b0;
        end else begin
            o_xm <= '{valid: i_dx.valid, pc: i_dx.pc, insn: i_dx.insn, ctrl: i_dx.ctrl,
                      result: result, store_data: rt_val,
                      nzp: lc4_pkg::nzp_of(result)};
        end
    end

endmodule

/* lc4_decode.sv */
module lc4_decode (
    input  logic               gwe,
    input  logic               i_reset,
    input  lc4_pkg::fd_t       i_fd,
    input  lc4_pkg::redirect_t i_redirect,
    input  lc4_pkg::rf_write_t i_wr,
    output logic               o_stall,
    output lc4_pkg::dx_t       o_dx
);

    lc4_pkg::insn_t  insn;
    lc4_pkg::ctrl_t  ctrl;
    lc4_pkg::word_t  rs_data;
    lc4_pkg::word_t  rt_data;
    logic            reg_form;

    assign insn = i_fd.insn;

    always_comb begin
        ctrl          = '0;
        reg_form      = 1'b0;
        ctrl.rs       = insn[8:6];
        ctrl.rt       = insn[2:0];
        ctrl.rd       = insn[11:9];
        ctrl.alu_op   = lc4_pkg::alu_add;
        case (insn[15:12])
            lc4_pkg::op_br: begin
                ctrl.is_branch = 1'b1;
                ctrl.br_mask   = insn[11:9];
                ctrl.imm       = {{7{insn[8]}}, insn[8:0]};
            end
            lc4_pkg::op_add: begin
                if (insn[5]) begin
                    // ADD with imm5
                    ctrl.rs_re   = 1'b1;
                    ctrl.rd_we   = 1'b1;
                    ctrl.nzp_we  = 1'b1;
                    ctrl.use_imm = 1'b1;
                    ctrl.imm     = {{11{insn[4]}}, insn[4:0]};
                end else if (insn[5:3] == lc4_pkg::sub_add) begin
                    reg_form = 1'b1;
                end else if (insn[5:3] == lc4_pkg::sub_sub) begin
                    reg_form    = 1'b1;
                    ctrl.alu_op = lc4_pkg::alu_sub;
                end
            end
            lc4_pkg::op_and: begin
                if (insn[5:3] == lc4_pkg::sub_and) begin
                    reg_form    = 1'b1;
                    ctrl.alu_op = lc4_pkg::alu_and;
                end else if (insn[5:3] == lc4_pkg::sub_or) begin
                    reg_form    = 1'b1;
                    ctrl.alu_op = lc4_pkg::alu_or;
                end else if (insn[5:3] == lc4_pkg::sub_xor) begin
                    reg_form    = 1'b1;
                    ctrl.alu_op = lc4_pkg::alu_xor;
                end
            end
            lc4_pkg::op_const: begin
                ctrl.rd_we   = 1'b1;
                ctrl.nzp_we  = 1'b1;
                ctrl.alu_op  = lc4_pkg::alu_pass;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = {{7{insn[8]}}, insn[8:0]};
            end
            lc4_pkg::op_ldr: begin
                ctrl.rs_re   = 1'b1;
                ctrl.rd_we   = 1'b1;
                ctrl.nzp_we  = 1'b1;
                ctrl.is_load = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = {{10{insn[5]}}, insn[5:0]};
            end
            lc4_pkg::op_str: begin
                // store data comes from insn[11:9]
                ctrl.rt       = insn[11:9];
                ctrl.rs_re    = 1'b1;
                ctrl.rt_re    = 1'b1;
                ctrl.is_store = 1'b1;
                ctrl.use_imm  = 1'b1;
                ctrl.imm      = {{10{insn[5]}}, insn[5:0]};
            end
            default: begin
                // anything else retires as a no-op
            end
        endcase
        if (reg_form) begin
            ctrl.rs_re  = 1'b1;
            ctrl.rt_re  = 1'b1;
            ctrl.rd_we  = 1'b1;
            ctrl.nzp_we = 1'b1;
        end
    end

    lc4_regfile regfile_i (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_rs      (ctrl.rs),
        .i_rt      (ctrl.rt),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_wr      (i_wr)
    );

    // load in execute feeding the instruction in decode
    assign o_stall = i_fd.valid && o_dx.valid && o_dx.ctrl.is_load &&
                     ((ctrl.rs_re && ctrl.rs == o_dx.ctrl.rd) ||
                      (ctrl.rt_re && ctrl.rt == o_dx.ctrl.rd));

    always_ff @(posedge gwe) begin
        if (i_reset || i_redirect.taken || o_stall) begin
            o_dx.valid <= 1'b0;
        end else begin
            o_dx <= '{valid: i_fd.valid, pc: i_fd.pc, insn: insn, ctrl: ctrl,
                      rs_data: rs_data, rt_data: rt_data};
        end
    end

endmodule

/* lc4_regfile.sv */
module lc4_regfile (
    input  logic                gwe,
    input  logic                i_reset,
    input  lc4_pkg::reg_sel_t   i_rs,
    input  lc4_pkg::reg_sel_t   i_rt,
    output lc4_pkg::word_t      o_rs_data,
    output lc4_pkg::word_t      o_rt_data,
    input  lc4_pkg::rf_write_t  i_wr
);

    lc4_pkg::word_t regs [8];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr.we) begin
            regs[i_wr.rd] <= i_wr.data;
        end
    end

    // same-cycle write shows up on the read ports
    assign o_rs_data = (i_wr.we && i_wr.rd == i_rs) ? i_wr.data : regs[i_rs];
    assign o_rt_data = (i_wr.we && i_wr.rd == i_rt) ? i_wr.data : regs[i_rt];

endmodule

/* lc4_fetch.sv */
module lc4_fetch #(
    parameter lc4_pkg::word_t reset_pc = 16'h8200
) (
    input  logic               gwe,
    input  logic               i_reset,
    input  logic               i_stall,
    input  lc4_pkg::redirect_t i_redirect,
    output lc4_pkg::word_t     o_imem_addr,
    input  lc4_pkg::insn_t     i_imem_data,
    output lc4_pkg::fd_t       o_fd
);

    lc4_pkg::word_t pc;

    assign o_imem_addr = pc;

    // a taken branch wins over the load-use hold
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc <= reset_pc;
        end else if (i_redirect.taken) begin
            pc <= i_redirect.target;
        end else if (!i_stall) begin
            pc <= pc + 16'd1;
        end
    end

    // wrong-path word becomes a bubble, held word stays put during a stall
    always_ff @(posedge gwe) begin
        if (i_reset || i_redirect.taken) begin
            o_fd.valid <= 1'b0;
        end else if (!i_stall) begin
            o_fd <= '{valid: 1'b1, pc: pc, insn: i_imem_data};
        end
    end

endmodule

/* lc4_pkg.sv */
package lc4_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] insn_t;
    typedef logic [2:0]  reg_sel_t;
    // bit 2 negative, bit 1 zero, bit 0 positive
    typedef logic [2:0]  nzp_t;

    // major opcodes, insn[15:12]
    localparam logic [3:0] op_br    = 4'b0000;
    localparam logic [3:0] op_add   = 4'b0001;
    localparam logic [3:0] op_and   = 4'b0101;
    localparam logic [3:0] op_ldr   = 4'b0110;
    localparam logic [3:0] op_str   = 4'b0111;
    localparam logic [3:0] op_const = 4'b1001;

    // sub-opcodes, insn[5:3] of the register forms
    localparam logic [2:0] sub_add = 3'b000;
    localparam logic [2:0] sub_sub = 3'b010;
    localparam logic [2:0] sub_and = 3'b000;
    localparam logic [2:0] sub_or  = 3'b010;
    localparam logic [2:0] sub_xor = 3'b011;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass
    } alu_op_t;

    typedef struct packed {
        reg_sel_t rs, rt, rd;
        logic     rs_re, rt_re, rd_we, nzp_we;
        logic     is_load, is_store, is_branch;
        nzp_t     br_mask;
        alu_op_t  alu_op;
        logic     use_imm;
        word_t    imm;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        insn_t insn;
    } fd_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        insn_t insn;
        ctrl_t ctrl;
        word_t rs_data, rt_data;
    } dx_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        insn_t insn;
        ctrl_t ctrl;
        word_t result, store_data;
        nzp_t  nzp;
    } xm_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        insn_t insn;
        ctrl_t ctrl;
        word_t result;
        nzp_t  nzp;
    } mw_t;

    typedef struct packed {
        logic     valid, we;
        reg_sel_t rd;
        word_t    data;
        logic     nzp_we;
        nzp_t     nzp;
    } fwd_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic  we;
        word_t addr, wdata;
    } dmem_req_t;

    typedef struct packed {
        logic     we;
        reg_sel_t rd;
        word_t    data;
    } rf_write_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        insn_t    insn;
        logic     rd_we;
        reg_sel_t rd;
        word_t    data;
        logic     nzp_we;
        nzp_t     nzp;
    } wb_trace_t;

    // condition bits of a signed 16-bit value
    function automatic nzp_t nzp_of(word_t value);
        if (value == '0) begin
            return 3'b010;
        end
        return value[15] ? 3'b100 : 3'b001;
    endfunction

endpackage
